//--- project.f
rtl/ooo_pkg.sv
rtl/phys_regfile.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/mult_unit.sv
rtl/cdb_arbiter.sv
rtl/issue_core.sv
tests/issue_core_checker.sv
tests/issue_core_tb.sv

//--- tests/issue_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb;
  import ooo_pkg::*;

  localparam int DATA_WIDTH = 32;
  localparam int NUM_PREG = 32;
  localparam int ROB_SIZE = 16;
  localparam int MULT_STAGES = 3;
  localparam int TAG_W = $clog2(NUM_PREG);
  localparam int ROB_W = $clog2(ROB_SIZE);
  localparam int PERIOD = 40;
  localparam int NUM_TESTS = 5;
  localparam int NUM_OPS = 30;     // Dispatch attempts over all tests rounded up
  localparam int OP_BOUND = 24;    // Cycles per micro-op with every slot busy
  localparam int DRAIN_LIMIT = 64;
  localparam int SETTLE = 8;       // Quiet cycles that catch late or repeated broadcasts
  localparam int WATCHDOG_NS =
    (NUM_OPS * OP_BOUND + NUM_TESTS * (DRAIN_LIMIT + SETTLE + 4) + 40) * PERIOD;
  localparam logic [TAG_W-1:0] DEAD_TAG = TAG_W'(NUM_PREG - 1); // Never broadcast

  logic                  clock;
  logic                  reset;
  logic                  dispatch_en;
  fu_type_t              dispatch_fu;
  func_t                 dispatch_func;
  logic [TAG_W-1:0]      dispatch_dest;
  logic [TAG_W-1:0]      dispatch_src1;
  logic [TAG_W-1:0]      dispatch_src2;
  logic [ROB_W-1:0]      dispatch_rob_idx;
  logic                  rollback_en;
  logic [ROB_W-1:0]      rob_tail_idx;
  logic [ROB_W-1:0]      rob_rollback_idx;
  logic                  load_en;
  logic [TAG_W-1:0]      load_tag;
  logic [DATA_WIDTH-1:0] load_value;
  logic                  dispatch_accept;
  logic                  cdb_valid;
  logic [TAG_W-1:0]      cdb_tag;
  logic [DATA_WIDTH-1:0] cdb_value;
  logic [ROB_W-1:0]      cdb_rob_idx;
  logic                  exp_valid;
  logic [TAG_W-1:0]      exp_tag;
  logic [DATA_WIDTH-1:0] exp_value;
  logic [ROB_W-1:0]      exp_rob;
  logic                  acc_check;
  logic                  acc_expect;
  logic                  test_end;
  logic [7:0]            test_num;
  int                    pending;
  int                    checked_count;
  int                    error_count;

  logic [31:0]           lfsr = 32'h8b98_6f77;
  logic [DATA_WIDTH-1:0] model [NUM_PREG];  // Expected register values on the rename side
  logic [TAG_W-1:0]      next_tag = TAG_W'(9);
  logic [ROB_W-1:0]      next_rob = '0;

  issue_core #(
    .DATA_WIDTH(DATA_WIDTH), .NUM_PREG(NUM_PREG), .ROB_SIZE(ROB_SIZE),
    .MULT_STAGES(MULT_STAGES)
  ) issue_core_i (
    .clock, .reset, .dispatch_en, .dispatch_fu, .dispatch_func, .dispatch_dest,
    .dispatch_src1, .dispatch_src2, .dispatch_rob_idx, .rollback_en, .rob_tail_idx,
    .rob_rollback_idx, .load_en, .load_tag, .load_value, .dispatch_accept,
    .cdb_valid, .cdb_tag, .cdb_value, .cdb_rob_idx
  );

  issue_core_checker #(
    .DATA_WIDTH(DATA_WIDTH), .NUM_PREG(NUM_PREG), .ROB_SIZE(ROB_SIZE)
  ) checker_i (
    .clock, .reset, .dispatch_accept, .exp_valid, .exp_tag, .exp_value, .exp_rob,
    .acc_check, .acc_expect, .cdb_valid, .cdb_tag, .cdb_value, .cdb_rob_idx,
    .test_end, .test_num, .pending, .checked_count, .error_count
  );

  always #(PERIOD / 2) clock = ~clock;

  // Taps 32, 22, 2 and 1 with one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic fb;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expected_result(input func_t func,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    case (func)
      func_add: return a + b;
      func_sub: return a - b;
      func_and: return a & b;
      func_xor: return a ^ b;
      func_mul: return a * b; // Low word
      default:  return '0;
    endcase
  endfunction

  function automatic logic [TAG_W-1:0] new_tag();
    logic [TAG_W-1:0] t;
    t = next_tag;
    next_tag = (next_tag == DEAD_TAG - 1) ? TAG_W'(9) : next_tag + 1'b1;
    return t;
  endfunction

  function automatic logic [TAG_W-1:0] rand_src(); // One of the loaded registers
    return TAG_W'(take_bits(3) + 1);
  endfunction

  task automatic drive_dispatch(input fu_type_t fu, input func_t func,
      input logic [TAG_W-1:0] dest, input logic [TAG_W-1:0] src1,
      input logic [TAG_W-1:0] src2, input logic [DATA_WIDTH-1:0] value,
      input bit tracked);
    dispatch_en = 1'b1;
    dispatch_fu = fu;
    dispatch_func = func;
    dispatch_dest = dest;
    dispatch_src1 = src1;
    dispatch_src2 = src2;
    dispatch_rob_idx = next_rob;
    exp_valid = tracked;
    exp_tag = dest;
    exp_value = value;
    exp_rob = next_rob;
    acc_check = 1'b0;
  endtask

  // Retries until the station takes the micro-op
  task automatic dispatch_op(input fu_type_t fu, input func_t func,
      input logic [TAG_W-1:0] dest, input logic [TAG_W-1:0] src1,
      input logic [TAG_W-1:0] src2, input bit tracked);
    logic [DATA_WIDTH-1:0] value;
    bit taken;
    value = expected_result(func, model[src1], model[src2]);
    taken = 1'b0;
    while (!taken) begin
      @(negedge clock);
      drive_dispatch(fu, func, dest, src1, src2, value, tracked);
      @(posedge clock);
      taken = dispatch_accept;
    end
    model[dest] = value;
    next_rob = next_rob + 1'b1;
  endtask

  // One attempt with the accept level checked
  task automatic probe_accept(input fu_type_t fu, input func_t func,
      input logic [TAG_W-1:0] dest, input logic [TAG_W-1:0] src1,
      input logic [TAG_W-1:0] src2, input bit expect_accept);
    logic [DATA_WIDTH-1:0] value;
    value = expected_result(func, model[src1], model[src2]);
    @(negedge clock);
    drive_dispatch(fu, func, dest, src1, src2, value, expect_accept);
    acc_check = 1'b1;
    acc_expect = expect_accept;
    @(posedge clock);
    if (dispatch_accept) begin
      model[dest] = value;
      next_rob = next_rob + 1'b1;
    end
  endtask

  task automatic dispatch_stop();
    @(negedge clock);
    dispatch_en = 1'b0;
    exp_valid = 1'b0;
    acc_check = 1'b0;
  endtask

  task automatic squash_range(input logic [ROB_W-1:0] tail, input logic [ROB_W-1:0] rollback);
    @(negedge clock);
    dispatch_en = 1'b0;
    exp_valid = 1'b0;
    acc_check = 1'b0;
    rollback_en = 1'b1;
    rob_tail_idx = tail;
    rob_rollback_idx = rollback;
    @(negedge clock);
    rollback_en = 1'b0;
  endtask

  // Waits for outstanding results, then lets the checker close the test
  task automatic finish_test(input int num);
    int waited;
    waited = 0;
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    repeat (SETTLE) @(negedge clock);
    test_end = 1'b1;
    test_num = 8'(num);
    @(negedge clock);
    test_end = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  initial begin
    fu_type_t fu;
    func_t func;
    logic [TAG_W-1:0] g;
    logic [TAG_W-1:0] s;
    clock = 1'b0;
    reset = 1'b1;
    dispatch_en = 1'b0;
    dispatch_fu = fu_alu;
    dispatch_func = func_add;
    dispatch_dest = '0;
    dispatch_src1 = '0;
    dispatch_src2 = '0;
    dispatch_rob_idx = '0;
    rollback_en = 1'b0;
    rob_tail_idx = '0;
    rob_rollback_idx = '0;
    load_en = 1'b0;
    load_tag = '0;
    load_value = '0;
    exp_valid = 1'b0;
    exp_tag = '0;
    exp_value = '0;
    exp_rob = '0;
    acc_check = 1'b0;
    acc_expect = 1'b0;
    test_end = 1'b0;
    test_num = '0;
    for (int r = 0; r < NUM_PREG; r++)
      model[r] = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    for (int r = 1; r <= 8; r++) begin // Architectural state in tags 1 to 8
      @(negedge clock);
      load_en = 1'b1;
      load_tag = TAG_W'(r);
      load_value = take_bits(32);
      model[r] = load_value;
    end
    @(negedge clock);
    load_en = 1'b0;

    // Independent micro-ops on loaded registers
    for (int n = 0; n < 6; n++) begin
      fu = fu_type_t'(take_bits(1));
      func = (fu == fu_mult) ? func_mul : func_t'(3'(take_bits(2)));
      dispatch_op(fu, func, new_tag(), rand_src(), rand_src(), 1'b1);
    end
    dispatch_stop();
    finish_test(1);

    // Dependent chain through both unit types
    g = new_tag();
    dispatch_op(fu_alu, func_add, g, rand_src(), rand_src(), 1'b1);
    s = new_tag();
    dispatch_op(fu_alu, func_sub, s, g, rand_src(), 1'b1);
    g = new_tag();
    dispatch_op(fu_mult, func_mul, g, s, s, 1'b1);
    s = new_tag();
    dispatch_op(fu_alu, func_xor, s, g, rand_src(), 1'b1);
    dispatch_op(fu_alu, func_and, new_tag(), s, g, 1'b1);
    dispatch_stop();
    finish_test(2);

    // ALUs wake on the first product while the second one lands
    g = new_tag();
    dispatch_op(fu_mult, func_mul, g, rand_src(), rand_src(), 1'b1);
    dispatch_op(fu_mult, func_mul, new_tag(), rand_src(), rand_src(), 1'b1);
    dispatch_op(fu_alu, func_add, new_tag(), g, rand_src(), 1'b1);
    dispatch_op(fu_alu, func_xor, new_tag(), rand_src(), g, 1'b1);
    dispatch_op(fu_mult, func_mul, new_tag(), g, rand_src(), 1'b1);
    dispatch_op(fu_alu, func_sub, new_tag(), rand_src(), rand_src(), 1'b1);
    dispatch_stop();
    finish_test(3);

    // Squashed producer leaves its tag unready for good
    next_rob = ROB_W'(14);
    dispatch_op(fu_alu, func_add, DEAD_TAG, rand_src(), rand_src(), 1'b0);
    squash_range(ROB_W'(14), ROB_W'(15));
    dispatch_op(fu_alu, func_add, new_tag(), DEAD_TAG, rand_src(), 1'b0); // rob 15
    dispatch_op(fu_alu, func_sub, new_tag(), rand_src(), DEAD_TAG, 1'b0); // rob 0
    g = new_tag();
    repeat (3) probe_accept(fu_alu, func_and, g, rand_src(), rand_src(), 1'b0);
    probe_accept(fu_mult, func_mul, new_tag(), rand_src(), rand_src(), 1'b1);
    dispatch_stop();
    finish_test(4);

    // Wrapped squash of the stuck ALU entries while the survivor waits on a product
    g = new_tag();
    dispatch_op(fu_mult, func_mul, g, rand_src(), rand_src(), 1'b1);
    s = new_tag();
    dispatch_op(fu_mult, func_mul, s, g, rand_src(), 1'b1);
    squash_range(ROB_W'(15), ROB_W'(2));
    dispatch_op(fu_alu, func_add, new_tag(), rand_src(), rand_src(), 1'b1);
    dispatch_op(fu_alu, func_xor, new_tag(), s, rand_src(), 1'b1);
    dispatch_stop();
    finish_test(5);

    $display("Summary: %0d tests, %0d broadcasts checked, %0d errors",
             NUM_TESTS, checked_count, error_count);
    if (error_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/issue_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module issue_core_checker #(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_PREG = 32,
  parameter int ROB_SIZE = 16,
  localparam int TAG_W = $clog2(NUM_PREG),
  localparam int ROB_W = $clog2(ROB_SIZE)
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  dispatch_accept,
  input  wire logic                  exp_valid,   // Expectation offered with a dispatch
  input  wire logic [TAG_W-1:0]      exp_tag,
  input  wire logic [DATA_WIDTH-1:0] exp_value,
  input  wire logic [ROB_W-1:0]      exp_rob,
  input  wire logic                  acc_check,
  input  wire logic                  acc_expect,
  input  wire logic                  cdb_valid,
  input  wire logic [TAG_W-1:0]      cdb_tag,
  input  wire logic [DATA_WIDTH-1:0] cdb_value,
  input  wire logic [ROB_W-1:0]      cdb_rob_idx,
  input  wire logic                  test_end,
  input  wire logic [7:0]            test_num,
  output int                         pending,
  output int                         checked_count,
  output int                         error_count
);

  logic [TAG_W-1:0]      q_tag [$];
  logic [DATA_WIDTH-1:0] q_value [$];
  logic [ROB_W-1:0]      q_rob [$];
  int                    checked_before; // Counts at the start of the running test
  int                    errors_before;

  always @(posedge clock) begin
    int hit;
    if (reset) begin
      q_tag.delete();
      q_value.delete();
      q_rob.delete();
      pending = 0;
      checked_count = 0;
      error_count = 0;
      checked_before = 0;
      errors_before = 0;
    end else begin
      if (acc_check && dispatch_accept !== acc_expect) begin
        $display("[FAIL] dispatch_accept: expected %h, got %h at %0t ns",
                 acc_expect, dispatch_accept, $time);
        error_count++;
      end
      if (exp_valid && dispatch_accept) begin
        q_tag.push_back(exp_tag);
        q_value.push_back(exp_value);
        q_rob.push_back(exp_rob);
      end
      if (cdb_valid) begin
        hit = -1;
        for (int k = 0; k < q_tag.size(); k++) begin
          if (hit < 0 && q_tag[k] == cdb_tag)
            hit = k;
        end
        if (hit < 0) begin
          $display("Unexpected broadcast of tag %0d with rob index %0d at %0t ns",
                   cdb_tag, cdb_rob_idx, $time);
          error_count++;
        end else begin
          checked_count++;
          if (cdb_value !== q_value[hit]) begin
            $display("[FAIL] cdb_value for tag %0d: expected %h, got %h",
                     cdb_tag, q_value[hit], cdb_value);
            error_count++;
          end
          if (cdb_rob_idx !== q_rob[hit]) begin
            $display("[FAIL] cdb_rob_idx for tag %0d: expected %h, got %h",
                     cdb_tag, q_rob[hit], cdb_rob_idx);
            error_count++;
          end
          q_tag.delete(hit); // Each result counts once
          q_value.delete(hit);
          q_rob.delete(hit);
        end
      end
      if (test_end) begin
        while (q_tag.size() > 0) begin
          $display("Test %0d ended with tag %0d (rob index %0d) never broadcast",
                   test_num, q_tag[0], q_rob[0]);
          error_count++;
          void'(q_tag.pop_front());
          void'(q_value.pop_front());
          void'(q_rob.pop_front());
        end
        $display("Test %0d done: %0d broadcasts checked, %0d errors", test_num,
                 checked_count - checked_before, error_count - errors_before);
        checked_before = checked_count;
        errors_before = error_count;
      end
      pending = q_tag.size();
    end
  end

endmodule

`default_nettype wire

//--- rtl/issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module issue_core #(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_PREG = 32,
  parameter int ROB_SIZE = 16,
  parameter int MULT_STAGES = 3,
  localparam int TAG_W = $clog2(NUM_PREG),
  localparam int ROB_W = $clog2(ROB_SIZE)
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  dispatch_en,
  input  wire ooo_pkg::fu_type_t     dispatch_fu,
  input  wire ooo_pkg::func_t        dispatch_func,
  input  wire logic [TAG_W-1:0]      dispatch_dest,
  input  wire logic [TAG_W-1:0]      dispatch_src1,
  input  wire logic [TAG_W-1:0]      dispatch_src2,
  input  wire logic [ROB_W-1:0]      dispatch_rob_idx,
  input  wire logic                  rollback_en,
  input  wire logic [ROB_W-1:0]      rob_tail_idx,
  input  wire logic [ROB_W-1:0]      rob_rollback_idx,
  input  wire logic                  load_en,
  input  wire logic [TAG_W-1:0]      load_tag,
  input  wire logic [DATA_WIDTH-1:0] load_value,
  output logic                       dispatch_accept,
  output logic                       cdb_valid,
  output logic [TAG_W-1:0]           cdb_tag,
  output logic [DATA_WIDTH-1:0]      cdb_value,
  output logic [ROB_W-1:0]           cdb_rob_idx
);
  import ooo_pkg::*;

  logic                  src1_ready;
  logic                  src2_ready;
  logic                  alloc_en;
  logic [NUM_FU-1:0]     issue_valid;
  func_t                 issue_func [NUM_FU];
  logic [TAG_W-1:0]      issue_dest [NUM_FU];
  logic [ROB_W-1:0]      issue_rob_idx [NUM_FU];
  logic [TAG_W-1:0]      issue_src1 [NUM_FU];
  logic [TAG_W-1:0]      issue_src2 [NUM_FU];
  logic [TAG_W-1:0]      read_tag [NUM_FU][2];
  logic [DATA_WIDTH-1:0] read_value [NUM_FU][2];
  logic [NUM_FU-1:0]     fu_ready;
  logic [NUM_FU-1:0]     result_valid;
  logic [TAG_W-1:0]      result_tag [NUM_FU];
  logic [DATA_WIDTH-1:0] result_value [NUM_FU];
  logic [ROB_W-1:0]      result_rob_idx [NUM_FU];
  logic [NUM_FU-1:0]     grant;

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      read_tag[i][0] = issue_src1[i]; // Operand fetch per slot
      read_tag[i][1] = issue_src2[i];
    end
  end

  phys_regfile #(.DATA_WIDTH(DATA_WIDTH), .NUM_PREG(NUM_PREG)) regfile_i (
    .clock, .reset, .load_en, .load_tag, .load_value,
    .alloc_en, .alloc_tag(dispatch_dest),
    .src1_tag(dispatch_src1), .src2_tag(dispatch_src2),
    .read_tag, .cdb_valid, .cdb_tag, .cdb_value,
    .src1_ready, .src2_ready, .read_value
  );

  reservation_station #(.NUM_PREG(NUM_PREG), .ROB_SIZE(ROB_SIZE)) station_i (
    .clock, .reset, .dispatch_en, .dispatch_fu, .dispatch_func, .dispatch_dest,
    .dispatch_src1, .dispatch_src2, .dispatch_rob_idx, .src1_ready, .src2_ready,
    .rollback_en, .rob_tail_idx, .rob_rollback_idx, .cdb_valid, .cdb_tag,
    .fu_ready, .dispatch_accept, .alloc_en, .issue_valid, .issue_func,
    .issue_dest, .issue_rob_idx, .issue_src1, .issue_src2
  );

  for (genvar i = 0; i < NUM_FU; i++) begin : gen_slot
    if (slot_type(i) == fu_alu) begin : gen_alu
      alu_unit #(.DATA_WIDTH(DATA_WIDTH), .NUM_PREG(NUM_PREG), .ROB_SIZE(ROB_SIZE)) alu_i (
        .clock, .reset, .issue_valid(issue_valid[i]), .issue_func(issue_func[i]),
        .issue_dest(issue_dest[i]), .issue_rob_idx(issue_rob_idx[i]),
        .src1_value(read_value[i][0]), .src2_value(read_value[i][1]),
        .grant(grant[i]), .fu_ready(fu_ready[i]), .result_valid(result_valid[i]),
        .result_tag(result_tag[i]), .result_value(result_value[i]),
        .result_rob_idx(result_rob_idx[i])
      );
    end else begin : gen_mult
      mult_unit #(
        .DATA_WIDTH(DATA_WIDTH), .NUM_PREG(NUM_PREG), .ROB_SIZE(ROB_SIZE),
        .MULT_STAGES(MULT_STAGES)
      ) mult_i (
        .clock, .reset, .issue_valid(issue_valid[i]),
        .issue_dest(issue_dest[i]), .issue_rob_idx(issue_rob_idx[i]),
        .src1_value(read_value[i][0]), .src2_value(read_value[i][1]),
        .grant(grant[i]), .fu_ready(fu_ready[i]), .result_valid(result_valid[i]),
        .result_tag(result_tag[i]), .result_value(result_value[i]),
        .result_rob_idx(result_rob_idx[i])
      );
    end
  end

  cdb_arbiter #(.DATA_WIDTH(DATA_WIDTH), .NUM_PREG(NUM_PREG), .ROB_SIZE(ROB_SIZE)) arbiter_i (
    .clock, .reset, .result_valid, .result_tag, .result_value, .result_rob_idx,
    .grant, .cdb_valid, .cdb_tag, .cdb_value, .cdb_rob_idx
  );

endmodule

`default_nettype wire

//--- rtl/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_PREG = 32,
  parameter int ROB_SIZE = 16,
  localparam int TAG_W = $clog2(NUM_PREG),
  localparam int ROB_W = $clog2(ROB_SIZE)
) (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire logic [ooo_pkg::NUM_FU-1:0] result_valid,
  input  wire logic [TAG_W-1:0]           result_tag [ooo_pkg::NUM_FU],
  input  wire logic [DATA_WIDTH-1:0]      result_value [ooo_pkg::NUM_FU],
  input  wire logic [ROB_W-1:0]           result_rob_idx [ooo_pkg::NUM_FU],
  output logic [ooo_pkg::NUM_FU-1:0]      grant,
  output logic                            cdb_valid,
  output logic [TAG_W-1:0]                cdb_tag,
  output logic [DATA_WIDTH-1:0]           cdb_value,
  output logic [ROB_W-1:0]                cdb_rob_idx
);
  import ooo_pkg::*;

  localparam int PTR_W = $clog2(NUM_FU);

  logic [PTR_W-1:0] last_winner;
  logic [PTR_W-1:0] winner;

  // Search starts one slot past the previous winner
  always_comb begin
    int idx;
    grant     = '0;
    winner    = '0;
    cdb_valid = 1'b0;
    for (int k = 1; k <= NUM_FU; k++) begin
      idx = (int'(last_winner) + k) % NUM_FU;
      if (!cdb_valid && result_valid[idx]) begin
        grant[idx] = 1'b1;
        winner     = PTR_W'(idx);
        cdb_valid  = 1'b1;
      end
    end
  end

  assign cdb_tag     = result_tag[winner];
  assign cdb_value   = result_value[winner];
  assign cdb_rob_idx = result_rob_idx[winner];

  always_ff @(posedge clock) begin
    if (reset)
      last_winner <= PTR_W'(NUM_FU - 1); // Slot 0 goes first
    else if (cdb_valid)
      last_winner <= winner;
  end

endmodule

`default_nettype wire

//--- rtl/mult_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mult_unit #(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_PREG = 32,
  parameter int ROB_SIZE = 16,
  parameter int MULT_STAGES = 3,
  localparam int TAG_W = $clog2(NUM_PREG),
  localparam int ROB_W = $clog2(ROB_SIZE)
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  issue_valid,
  input  wire logic [TAG_W-1:0]      issue_dest,
  input  wire logic [ROB_W-1:0]      issue_rob_idx,
  input  wire logic [DATA_WIDTH-1:0] src1_value,
  input  wire logic [DATA_WIDTH-1:0] src2_value,
  input  wire logic                  grant,
  output logic                       fu_ready,
  output logic                       result_valid,
  output logic [TAG_W-1:0]           result_tag,
  output logic [DATA_WIDTH-1:0]      result_value,
  output logic [ROB_W-1:0]           result_rob_idx
);

  localparam int LAST = MULT_STAGES - 1;

  logic [MULT_STAGES-1:0] stage_valid;
  logic [TAG_W-1:0]       stage_tag [MULT_STAGES];
  logic [ROB_W-1:0]       stage_rob [MULT_STAGES];
  logic [DATA_WIDTH-1:0]  stage_prod [MULT_STAGES];
  logic                   stall;

  // Whole pipe freezes while the last stage waits for the bus
  assign stall    = stage_valid[LAST] && !grant;
  assign fu_ready = !stall;

  assign result_valid   = stage_valid[LAST];
  assign result_tag     = stage_tag[LAST];
  assign result_value   = stage_prod[LAST];
  assign result_rob_idx = stage_rob[LAST];

  always_ff @(posedge clock) begin
    if (reset)
      stage_valid <= '0;
    else if (!stall) begin
      stage_valid[0] <= issue_valid;
      for (int s = 1; s < MULT_STAGES; s++)
        stage_valid[s] <= stage_valid[s-1];
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      stage_tag[0]  <= issue_dest;
      stage_rob[0]  <= issue_rob_idx;
      stage_prod[0] <= src1_value * src2_value; // Low word only
      for (int s = 1; s < MULT_STAGES; s++) begin
        stage_tag[s]  <= stage_tag[s-1];
        stage_rob[s]  <= stage_rob[s-1];
        stage_prod[s] <= stage_prod[s-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_PREG = 32,
  parameter int ROB_SIZE = 16,
  localparam int TAG_W = $clog2(NUM_PREG),
  localparam int ROB_W = $clog2(ROB_SIZE)
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  issue_valid,
  input  wire ooo_pkg::func_t        issue_func,
  input  wire logic [TAG_W-1:0]      issue_dest,
  input  wire logic [ROB_W-1:0]      issue_rob_idx,
  input  wire logic [DATA_WIDTH-1:0] src1_value,
  input  wire logic [DATA_WIDTH-1:0] src2_value,
  input  wire logic                  grant,
  output logic                       fu_ready,
  output logic                       result_valid,
  output logic [TAG_W-1:0]           result_tag,
  output logic [DATA_WIDTH-1:0]      result_value,
  output logic [ROB_W-1:0]           result_rob_idx
);
  import ooo_pkg::*;

  logic [DATA_WIDTH-1:0] alu_out;

  always_comb begin
    case (issue_func)
      func_add: alu_out = src1_value + src2_value;
      func_sub: alu_out = src1_value - src2_value;
      func_and: alu_out = src1_value & src2_value;
      func_xor: alu_out = src1_value ^ src2_value;
      default:  alu_out = '0; // Multiply never reaches an ALU slot
    endcase
  end

  assign fu_ready = !result_valid || grant; // Free once the bus takes the result

  always_ff @(posedge clock) begin
    if (reset)
      result_valid <= 1'b0;
    else if (issue_valid)
      result_valid <= 1'b1;
    else if (grant)
      result_valid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (issue_valid) begin
      result_tag     <= issue_dest;
      result_value   <= alu_out;
      result_rob_idx <= issue_rob_idx;
    end
  end

endmodule

`default_nettype wire

//--- rtl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
  parameter int NUM_PREG = 32,
  parameter int ROB_SIZE = 16,
  localparam int TAG_W = $clog2(NUM_PREG),
  localparam int ROB_W = $clog2(ROB_SIZE)
) (
  input  wire logic                           clock,
  input  wire logic                           reset,
  input  wire logic                           dispatch_en,
  input  wire ooo_pkg::fu_type_t              dispatch_fu,
  input  wire ooo_pkg::func_t                 dispatch_func,
  input  wire logic [TAG_W-1:0]               dispatch_dest,
  input  wire logic [TAG_W-1:0]               dispatch_src1,
  input  wire logic [TAG_W-1:0]               dispatch_src2,
  input  wire logic [ROB_W-1:0]               dispatch_rob_idx,
  input  wire logic                           src1_ready,
  input  wire logic                           src2_ready,
  input  wire logic                           rollback_en,
  input  wire logic [ROB_W-1:0]               rob_tail_idx,
  input  wire logic [ROB_W-1:0]               rob_rollback_idx,
  input  wire logic                           cdb_valid,
  input  wire logic [TAG_W-1:0]               cdb_tag,
  input  wire logic [ooo_pkg::NUM_FU-1:0]     fu_ready,
  output logic                                dispatch_accept,
  output logic                                alloc_en,
  output logic [ooo_pkg::NUM_FU-1:0]          issue_valid,
  output ooo_pkg::func_t                      issue_func [ooo_pkg::NUM_FU],
  output logic [TAG_W-1:0]                    issue_dest [ooo_pkg::NUM_FU],
  output logic [ROB_W-1:0]                    issue_rob_idx [ooo_pkg::NUM_FU],
  output logic [TAG_W-1:0]                    issue_src1 [ooo_pkg::NUM_FU],
  output logic [TAG_W-1:0]                    issue_src2 [ooo_pkg::NUM_FU]
);
  import ooo_pkg::*;

  logic [NUM_FU-1:0] busy;
  logic [NUM_FU-1:0] src1_rdy;
  logic [NUM_FU-1:0] src2_rdy;
  func_t             func [NUM_FU];
  logic [TAG_W-1:0]  dest [NUM_FU];
  logic [ROB_W-1:0]  rob_idx [NUM_FU];
  logic [TAG_W-1:0]  src1 [NUM_FU];
  logic [TAG_W-1:0]  src2 [NUM_FU];

  logic [NUM_FU-1:0] src1_wake;   // Stored ready or matched on the bus
  logic [NUM_FU-1:0] src2_wake;
  logic [NUM_FU-1:0] squash;
  logic [NUM_FU-1:0] entry_ready;
  logic [NUM_FU-1:0] empty;       // Free for dispatch this cycle
  logic [NUM_FU-1:0] match;       // Entry chosen for dispatch

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      src1_wake[i] = src1_rdy[i] || (cdb_valid && cdb_tag == src1[i]);
      src2_wake[i] = src2_rdy[i] || (cdb_valid && cdb_tag == src2[i]);

      // The squashed range may wrap past the end of the ROB
      if (!rollback_en || !busy[i])
        squash[i] = 1'b0;
      else if (rob_tail_idx > rob_rollback_idx)
        squash[i] = rob_idx[i] >= rob_tail_idx || rob_idx[i] < rob_rollback_idx;
      else
        squash[i] = rob_idx[i] >= rob_tail_idx && rob_idx[i] < rob_rollback_idx;

      entry_ready[i] = busy[i] && src1_wake[i] && src2_wake[i] && !squash[i];
      issue_valid[i] = entry_ready[i] && fu_ready[i];
      empty[i]       = !busy[i] || issue_valid[i] || squash[i];
    end
  end

  // Lowest empty entry of the requested unit class
  always_comb begin
    match = '0;
    for (int i = 0; i < NUM_FU; i++) begin
      if (dispatch_en && empty[i] && slot_type(i) == dispatch_fu && match == '0)
        match[i] = 1'b1;
    end
  end

  assign dispatch_accept = |match;
  assign alloc_en        = dispatch_accept; // Regfile clears the dest ready bit

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      issue_func[i]    = func[i];
      issue_dest[i]    = dest[i];
      issue_rob_idx[i] = rob_idx[i];
      issue_src1[i]    = src1[i];
      issue_src2[i]    = src2[i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= '0;
      src1_rdy <= '0;
      src2_rdy <= '0;
    end else begin
      for (int i = 0; i < NUM_FU; i++) begin
        if (match[i]) begin
          busy[i]     <= 1'b1;
          src1_rdy[i] <= src1_ready;
          src2_rdy[i] <= src2_ready;
        end else if (empty[i]) begin
          busy[i] <= 1'b0; // Issued, squashed or idle
        end else begin
          src1_rdy[i] <= src1_wake[i];
          src2_rdy[i] <= src2_wake[i];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_FU; i++) begin
      if (match[i]) begin
        func[i]    <= dispatch_func;
        dest[i]    <= dispatch_dest;
        rob_idx[i] <= dispatch_rob_idx;
        src1[i]    <= dispatch_src1;
        src2[i]    <= dispatch_src2;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile #(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_PREG = 32,
  localparam int TAG_W = $clog2(NUM_PREG)
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  load_en,
  input  wire logic [TAG_W-1:0]      load_tag,
  input  wire logic [DATA_WIDTH-1:0] load_value,
  input  wire logic                  alloc_en,
  input  wire logic [TAG_W-1:0]      alloc_tag,
  input  wire logic [TAG_W-1:0]      src1_tag,
  input  wire logic [TAG_W-1:0]      src2_tag,
  input  wire logic [TAG_W-1:0]      read_tag [ooo_pkg::NUM_FU][2],
  input  wire logic                  cdb_valid,
  input  wire logic [TAG_W-1:0]      cdb_tag,
  input  wire logic [DATA_WIDTH-1:0] cdb_value,
  output logic                       src1_ready,
  output logic                       src2_ready,
  output logic [DATA_WIDTH-1:0]      read_value [ooo_pkg::NUM_FU][2]
);
  import ooo_pkg::*;

  logic [DATA_WIDTH-1:0] regs [NUM_PREG];
  logic [NUM_PREG-1:0]   reg_ready;

  // A source broadcast this cycle is already ready at dispatch
  assign src1_ready = reg_ready[src1_tag] || (cdb_valid && cdb_tag == src1_tag);
  assign src2_ready = reg_ready[src2_tag] || (cdb_valid && cdb_tag == src2_tag);

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      for (int j = 0; j < 2; j++) begin
        if (cdb_valid && cdb_tag == read_tag[i][j])
          read_value[i][j] = cdb_value; // Bus bypass on wakeup cycle
        else
          read_value[i][j] = regs[read_tag[i][j]];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      regs <= '{default: '0};
      reg_ready <= '1;
    end else begin
      if (load_en) begin
        regs[load_tag] <= load_value;
        reg_ready[load_tag] <= 1'b1;
      end
      if (cdb_valid) begin
        regs[cdb_tag] <= cdb_value;
        reg_ready[cdb_tag] <= 1'b1;
      end
      if (alloc_en)
        reg_ready[alloc_tag] <= 1'b0; // Allocation wins over a broadcast
    end
  end

endmodule

`default_nettype wire

//--- rtl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  localparam int NUM_FU = 3; // Station entries, one per unit slot

  typedef enum logic [0:0] {
    fu_alu  = 1'b0,
    fu_mult = 1'b1
  } fu_type_t;

  typedef enum logic [2:0] {
    func_add = 3'd0,
    func_sub = 3'd1,
    func_and = 3'd2,
    func_xor = 3'd3,
    func_mul = 3'd4 // Multiplier only, low word of product
  } func_t;

  // Slots 0 and 1 are ALUs, the last slot is the multiplier
  function automatic fu_type_t slot_type(input int slot);
    fu_type_t kind;
    case (slot)
      0, 1: kind = fu_alu;
      2: kind = fu_mult;
      default: kind = fu_alu;
    endcase
    return kind;
  endfunction

endpackage

`default_nettype wire
